/* filelist.f */
common/pk_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
hdl/panel_cmd_decoder.sv
hdl/status_reporter.sv
hdl/panel_signals.sv
display/sevenseg_mux.sv
hdl/pk.sv
verif/pk_assertions.sv
verif/tb_pk.sv

/* Makefile */
# Verilator flow for the pk panel

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f filelist.f --top-module tb_pk

sim:
	verilator --binary --timing -f filelist.f --top-module tb_pk -Mdir obj_dir
	./obj_dir/Vtb_pk | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* verif/tb_pk.sv */
//////////////////////////////////////////////////
// pk testbench
// drives host commands over a uart model and
// checks machine lines, status frame and display
//////////////////////////////////////////////////
`timescale 1ns/10ps

module tb_pk import pk_pkg::*; ();

	localparam int CLK_HZ = 50_000_000;
	localparam int BIT_CLKS = CLK_HZ / 3_125_000;
	// 1 us pulse at 50 MHz
	localparam int KEY_PULSE_CYCLES = 50;
	localparam int TICK_CYCLES = CLK_HZ / 1_000;
	// about 70 frames of 10 bits, up to 75k cycles of display scan
	// and two tick periods, with margin
	localparam int TIMEOUT_CYCLES = 200_000;
	// segments g..a for hex digits
	localparam logic [6:0] HEX_SEG [16] = '{
		7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
		7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71
	};

	logic CLK_EXT, rst_n, RXD, TXD;
	logic [7:0] SEG, DIG;
	logic hlt_n, off, work, stop, start, mode, stop_n;
	logic p0, dcl, step, fetch, store, cycle, load, bin, oprq, zegar;
	word_t kl, w;
	logic p, mc_0, alarm, wait_in, irq, q, run;
	logic wre_, rsa, rsb, rsc, wic, wac, war, wir, wrs, wrz, wkb;
	logic [15:0] wv;

	int seed = 37478;
	int cyc = 0;
	int errors = 0;
	int n_tests = 0;
	int n_failed = 0;
	int start_cnt = 0;
	int stop_cnt = 0;
	int step_cnt = 0;
	int fetch_cnt = 0;
	int zegar_cnt = 0;
	int zegar_last = 0;
	int zegar_gap = 0;

	assign w = wv;

	pk #(.TIMER_CYCLE_MS(1), .CLK_EXT_HZ(CLK_HZ), .UART_BAUD(3_125_000)) dut (.*);

	initial CLK_EXT = 1'b0;
	always #10 CLK_EXT = ~CLK_EXT;

	always @(posedge CLK_EXT) begin
		cyc <= cyc + 1;
		if (cyc >= TIMEOUT_CYCLES) begin
			$display("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	// pulse counters for the machine lines
	always @(posedge CLK_EXT) begin
		if (start)
			start_cnt <= start_cnt + 1;
		if (stop)
			stop_cnt <= stop_cnt + 1;
		if (step)
			step_cnt <= step_cnt + 1;
		if (fetch)
			fetch_cnt <= fetch_cnt + 1;
		if (zegar) begin
			zegar_gap <= cyc - zegar_last;
			zegar_last <= cyc;
			zegar_cnt <= zegar_cnt + 1;
		end
	end

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("MISMATCH %s: got %h expected %h", name, got, exp);
		errors++;
	endtask

	task automatic end_test(input string name, input int err_base);
		n_tests++;
		if (errors == err_base) begin
			$display("test %s: ok", name);
		end else begin
			n_failed++;
			$display("test %s: %0d errors", name, errors - err_base);
		end
	endtask

	// 8N1, lsb first
	task automatic send_byte(input byte_t b);
		int i;
		@(negedge CLK_EXT);
		RXD = 1'b0;
		repeat (BIT_CLKS) @(negedge CLK_EXT);
		for (i = 0; i < 8; i++) begin
			RXD = b[i];
			repeat (BIT_CLKS) @(negedge CLK_EXT);
		end
		RXD = 1'b1;
		repeat (BIT_CLKS) @(negedge CLK_EXT);
	endtask

	task automatic receive_byte(output byte_t b);
		int i;
		while (TXD)
			@(negedge CLK_EXT);
		repeat (BIT_CLKS / 2) @(negedge CLK_EXT);
		for (i = 0; i < 8; i++) begin
			repeat (BIT_CLKS) @(negedge CLK_EXT);
			b[i] = TXD;
		end
		repeat (BIT_CLKS) @(negedge CLK_EXT);
		if (!TXD) begin
			$display("stop bit of a status byte is low");
			errors++;
		end
	endtask

	function automatic byte_t key_cmd(input fn_idx_e idx, input logic val);
		return {CMD_FNKEY, idx, val};
	endfunction

	// machine line driven by a momentary key
	function automatic logic key_line(input fn_idx_e idx);
		case (idx)
			FN_STORE: return store;
			FN_CYCLE: return cycle;
			FN_LOAD: return load;
			FN_BIN: return bin;
			FN_OPRQ: return oprq;
			FN_CLEAR: return dcl;
			default: return 1'bx;
		endcase
	endfunction

	task automatic check_key_pulse(input fn_idx_e idx, input string name);
		send_byte(key_cmd(idx, 1'b1));
		if (key_line(idx) !== 1'b1)
			report_mismatch(name, key_line(idx), 1);
		repeat (KEY_PULSE_CYCLES) @(negedge CLK_EXT);
		if (key_line(idx) !== 1'b0)
			report_mismatch(name, key_line(idx), 0);
	endtask

	task automatic test_data_keys();
		int err_base;
		int r;
		int n;
		logic [15:0] exp;
		err_base = errors;
		for (n = 0; n < 8; n++) begin
			r = $random(seed);
			exp = r[15:0];
			// keys_lo covers codes 2 and 3, bit 5 of the field sits in the code
			send_byte({2'b01, exp[5:0]});
			send_byte({CMD_KEYS_MID, exp[10:6]});
			send_byte({CMD_KEYS_HI, exp[15:11]});
			if (kl !== exp)
				report_mismatch("kl", kl, exp);
		end
		end_test("data keys", err_base);
	endtask

	task automatic test_rotary();
		int err_base;
		int pos;
		rot_bus_t got;
		err_base = errors;
		got = {wre_, rsc, rsb, rsa, wic, wac, war, wir, wrs, wrz, wkb};
		if (got !== ROT_BUS_R1)
			report_mismatch("rotary after reset", got, ROT_BUS_R1);
		for (pos = 0; pos < 16; pos++) begin
			send_byte({CMD_ROTARY, 1'b0, 4'(pos)});
			got = {wre_, rsc, rsb, rsa, wic, wac, war, wir, wrs, wrz, wkb};
			if (got !== ROT_BUS_TABLE[pos])
				report_mismatch("rotary bus", got, ROT_BUS_TABLE[pos]);
		end
		end_test("rotary switch", err_base);
	endtask

	task automatic test_fn_keys();
		int err_base;
		int s0;
		int p0_base;
		err_base = errors;
		s0 = start_cnt;
		p0_base = stop_cnt;
		send_byte(key_cmd(FN_START, 1'b1));
		repeat (4) @(negedge CLK_EXT);
		if (work !== 1'b1)
			report_mismatch("work", work, 1);
		if (start_cnt - s0 != 1 || stop_cnt != p0_base)
			report_mismatch("start pulses", start_cnt - s0, 1);
		send_byte(key_cmd(FN_START, 1'b0));
		repeat (4) @(negedge CLK_EXT);
		if (work !== 1'b0)
			report_mismatch("work", work, 0);
		if (stop_cnt - p0_base != 1 || start_cnt - s0 != 1)
			report_mismatch("stop pulses", stop_cnt - p0_base, 1);
		// momentary step, counted until it drops
		s0 = step_cnt;
		send_byte(key_cmd(FN_STEP, 1'b1));
		while (step)
			@(negedge CLK_EXT);
		if (step_cnt - s0 != KEY_PULSE_CYCLES)
			report_mismatch("step width", step_cnt - s0, KEY_PULSE_CYCLES);
		s0 = fetch_cnt;
		send_byte(key_cmd(FN_FETCH, 1'b1));
		repeat (KEY_PULSE_CYCLES + 4) @(negedge CLK_EXT);
		if (fetch_cnt != s0)
			report_mismatch("fetch with p0 low", fetch_cnt - s0, 0);
		p0 = 1'b1;
		send_byte(key_cmd(FN_FETCH, 1'b1));
		repeat (KEY_PULSE_CYCLES + 4) @(negedge CLK_EXT);
		if (fetch_cnt - s0 != KEY_PULSE_CYCLES)
			report_mismatch("fetch width", fetch_cnt - s0, KEY_PULSE_CYCLES);
		// p0 is still high for the memory keys
		check_key_pulse(FN_STORE, "store");
		check_key_pulse(FN_CYCLE, "cycle");
		check_key_pulse(FN_LOAD, "load");
		check_key_pulse(FN_BIN, "bin");
		check_key_pulse(FN_OPRQ, "oprq");
		check_key_pulse(FN_CLEAR, "dcl");
		p0 = 1'b0;
		if (stop_n !== 1'b0)
			report_mismatch("stop_n after reset", stop_n, 0);
		send_byte(key_cmd(FN_STOPN, 1'b1));
		repeat (KEY_PULSE_CYCLES + 4) @(negedge CLK_EXT);
		if (stop_n !== 1'b1)
			report_mismatch("stop_n", stop_n, 1);
		send_byte(key_cmd(FN_STOPN, 1'b1));
		repeat (KEY_PULSE_CYCLES + 4) @(negedge CLK_EXT);
		if (stop_n !== 1'b0)
			report_mismatch("stop_n", stop_n, 0);
		send_byte(key_cmd(FN_STOPN, 1'b1));
		repeat (KEY_PULSE_CYCLES + 4) @(negedge CLK_EXT);
		if (stop_n !== 1'b1)
			report_mismatch("stop_n", stop_n, 1);
		// hlt_n clears without waiting for a clock edge
		hlt_n = 1'b0;
		#1;
		if (stop_n !== 1'b0)
			report_mismatch("stop_n with hlt_n low", stop_n, 0);
		@(negedge CLK_EXT);
		hlt_n = 1'b1;
		end_test("function keys", err_base);
	endtask

	task automatic test_status();
		int err_base;
		int i;
		byte_t got [4];
		byte_t exp [4];
		byte_t b;
		err_base = errors;
		wv = 16'ha5c3;
		p = 1'b1;
		mc_0 = 1'b0;
		alarm = 1'b1;
		wait_in = 1'b0;
		irq = 1'b1;
		q = 1'b0;
		run = 1'b1;
		send_byte(key_cmd(FN_MODE, 1'b1));
		send_byte(key_cmd(FN_CLOCK, 1'b1));
		send_byte({CMD_ROTARY, 5'd9});
		if (mode !== 1'b1)
			report_mismatch("mode", mode, 1);
		// w bit 0 is the msb, so bits 0-7 are the upper byte
		exp[0] = wv[15:8];
		exp[1] = wv[7:0];
		// mode and clock keys set, stop_n cleared by hlt_n
		exp[2] = {1'b1, 1'b0, 1'b1, q, p, ~mc_0, irq, run};
		exp[3] = {4'd9, 2'b00, wait_in, alarm};
		fork
			send_byte({CMD_STATUS, 5'd0});
			for (i = 0; i < 4; i++) begin
				receive_byte(b);
				got[i] = b;
			end
		join
		for (i = 0; i < 4; i++) begin
			if (got[i] !== exp[i])
				report_mismatch($sformatf("status byte %0d", i), got[i], exp[i]);
		end
		send_byte(key_cmd(FN_CLOCK, 1'b0));
		end_test("status report", err_base);
	endtask

	task automatic test_display();
		int err_base;
		int d;
		logic [7:0] dots;
		logic [7:0] exp;
		err_base = errors;
		wv = 16'h3d9f;
		// digit 0 up to 7 carry the dots of q, clock, stop_n, mode, irq, alarm, wait, run
		dots = {run, wait_in, alarm, irq, 1'b1, 1'b0, 1'b0, q};
		for (d = 0; d < 5; d++) begin
			while (DIG !== 8'(1 << d))
				@(negedge CLK_EXT);
			// digit 4 is blank, digit 0 is the low nibble
			exp[6:0] = (d == 4) ? 7'h00 : HEX_SEG[4'(wv >> (4 * d))];
			exp[7] = dots[d];
			if (SEG !== exp)
				report_mismatch($sformatf("SEG on digit %0d", d), SEG, exp);
		end
		off = 1'b1;
		@(negedge CLK_EXT);
		if (DIG !== 8'h00)
			report_mismatch("DIG with off set", DIG, 8'h00);
		off = 1'b0;
		end_test("display", err_base);
	endtask

	task automatic test_clock_tick();
		int err_base;
		int z0;
		err_base = errors;
		z0 = zegar_cnt;
		send_byte(key_cmd(FN_CLOCK, 1'b1));
		while (zegar_cnt < z0 + 2)
			@(negedge CLK_EXT);
		if (zegar_gap != TICK_CYCLES)
			report_mismatch("zegar period", zegar_gap, TICK_CYCLES);
		send_byte(key_cmd(FN_CLOCK, 1'b0));
		end_test("clock tick", err_base);
	endtask

	initial begin
		rst_n = 1'b0;
		RXD = 1'b1;
		hlt_n = 1'b1;
		off = 1'b0;
		p0 = 1'b0;
		wv = '0;
		p = 1'b0;
		mc_0 = 1'b0;
		alarm = 1'b0;
		wait_in = 1'b0;
		irq = 1'b0;
		q = 1'b0;
		run = 1'b0;
		repeat (5) @(negedge CLK_EXT);
		rst_n = 1'b1;
		repeat (2) @(negedge CLK_EXT);
		test_data_keys();
		test_rotary();
		test_fn_keys();
		test_status();
		test_display();
		test_clock_tick();
		errors += dut.u_sig.u_assert.fail_cnt;
		$display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

/* verif/pk_assertions.sv */
//////////////////////////////////////////////////
// panel signal assertions
// pulse width, tick gating and p0 gating of the
// machine control lines
//////////////////////////////////////////////////
`timescale 1ns/10ps

module pk_assertions import pk_pkg::*; (
	input logic CLK_EXT,
	input logic rst_n,
	input fnkey_t fnkey,
	input logic p0,
	input logic start,
	input logic stop,
	input logic fetch,
	input logic zegar
);

	// read by the testbench at the end of the run
	int fail_cnt = 0;

	a_start_one: assert property (@(posedge CLK_EXT) disable iff (!rst_n)
		start |=> !start)
	else begin
		$error("start pulse longer than one cycle");
		fail_cnt++;
	end

	a_stop_one: assert property (@(posedge CLK_EXT) disable iff (!rst_n)
		stop |=> !stop)
	else begin
		$error("stop pulse longer than one cycle");
		fail_cnt++;
	end

	// no tick without the clock key
	a_zegar_gated: assert property (@(posedge CLK_EXT) disable iff (!rst_n)
		!fnkey[FN_CLOCK] |-> !zegar)
	else begin
		$error("zegar high while the clock key is clear");
		fail_cnt++;
	end

	a_fetch_gated: assert property (@(posedge CLK_EXT) disable iff (!rst_n)
		!p0 |-> !fetch)
	else begin
		$error("fetch high while p0 is low");
		fail_cnt++;
	end

endmodule

bind panel_signals pk_assertions u_assert (
	.CLK_EXT(CLK_EXT), .rst_n(rst_n), .fnkey(fnkey), .p0(p0),
	.start(start), .stop(stop), .fetch(fetch), .zegar(zegar)
);

/* hdl/pk.sv */
//////////////////////////////////////////////////
// pk operator control panel
// serial host link in, machine control lines,
// status frame and seven segment display out
//////////////////////////////////////////////////
`timescale 1ns/10ps

module pk import pk_pkg::*; #(
	parameter int TIMER_CYCLE_MS = 1,
	parameter int CLK_EXT_HZ = 50_000_000,
	parameter int UART_BAUD = 1_000_000
) (
	input logic CLK_EXT,
	input logic rst_n,
	input logic RXD,
	output logic TXD,
	output logic [7:0] SEG,
	output logic [7:0] DIG,
	// sheet 1
	input logic hlt_n,
	input logic off,
	output logic work,
	output logic stop,
	output logic start,
	output logic mode,
	output logic stop_n,
	// sheet 2
	input logic p0,
	output word_t kl,
	output logic dcl,
	output logic step,
	output logic fetch,
	output logic store,
	output logic cycle,
	output logic load,
	output logic bin,
	output logic oprq,
	// sheet 3
	output logic zegar,
	// sheet 4
	input word_t w,
	input logic p,
	input logic mc_0,
	input logic alarm,
	input logic wait_in,
	input logic irq,
	input logic q,
	input logic run,
	// sheet 5
	output logic wre_,
	output logic rsa,
	output logic rsb,
	output logic rsc,
	output logic wic,
	output logic wac,
	output logic war,
	output logic wir,
	output logic wrs,
	output logic wrz,
	output logic wkb
);

	localparam int CLKS_PER_BIT = CLK_EXT_HZ / UART_BAUD;
	localparam int TIMER_PERIOD = TIMER_CYCLE_MS * (CLK_EXT_HZ / 1_000);
	// 1 us key pulse
	localparam int KEY_PULSE_CYCLES = CLK_EXT_HZ / 1_000_000;
	// full display refresh at 1 kHz
	localparam int SCAN_CYCLES = CLK_EXT_HZ / 8_000;

	byte_t rx_byte;
	byte_t tx_byte;
	logic rx_valid;
	logic tx_send;
	logic tx_busy;
	logic status_req;
	logic [7:0] dig;
	panel_state_s state;
	mach_status_s mstat;

	assign mstat = '{w: w, p: p, mc_0: mc_0, alarm: alarm, wait_in: wait_in,
		irq: irq, q: q, run: run, stop_n: stop_n};

	uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
		.CLK_EXT(CLK_EXT), .rst_n(rst_n), .rxd(RXD),
		.rx_byte(rx_byte), .rx_valid(rx_valid)
	);

	uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
		.CLK_EXT(CLK_EXT), .rst_n(rst_n), .tx_byte(tx_byte),
		.tx_send(tx_send), .txd(TXD), .tx_busy(tx_busy)
	);

	panel_cmd_decoder #(.KEY_PULSE_CYCLES(KEY_PULSE_CYCLES)) u_dec (
		.CLK_EXT(CLK_EXT), .rst_n(rst_n), .rx_byte(rx_byte),
		.rx_valid(rx_valid), .state(state), .status_req(status_req)
	);

	status_reporter u_rep (
		.CLK_EXT(CLK_EXT), .rst_n(rst_n), .status_req(status_req),
		.tx_busy(tx_busy), .state(state), .mstat(mstat),
		.tx_byte(tx_byte), .tx_send(tx_send)
	);

	panel_signals #(.TIMER_PERIOD(TIMER_PERIOD)) u_sig (
		.CLK_EXT(CLK_EXT), .rst_n(rst_n), .fnkey(state.fnkey),
		.hlt_n(hlt_n), .p0(p0), .start(start), .stop(stop),
		.stop_n(stop_n), .fetch(fetch), .store(store), .cycle(cycle),
		.load(load), .bin(bin), .zegar(zegar)
	);

	sevenseg_mux #(.SCAN_CYCLES(SCAN_CYCLES)) u_disp (
		.CLK_EXT(CLK_EXT), .rst_n(rst_n), .mstat(mstat),
		.state(state), .seg(SEG), .dig(dig)
	);

	// machine powered off, display goes dark
	assign DIG = off ? 8'h00 : dig;

	assign work = state.fnkey[FN_START];
	assign mode = state.fnkey[FN_MODE];
	assign dcl = state.fnkey[FN_CLEAR];
	assign step = state.fnkey[FN_STEP];
	assign oprq = state.fnkey[FN_OPRQ];
	assign kl = state.keys;
	assign {wre_, rsc, rsb, rsa, wic, wac, war, wir, wrs, wrz, wkb} = state.rot_bus;

endmodule

/* display/sevenseg_mux.sv */
//////////////////////////////////////////////////
// seven segment display driver
// scans eight digits one at a time: w in hex,
// register name from the rotary bus, p and mc_0
//////////////////////////////////////////////////
`timescale 1ns/10ps

module sevenseg_mux import pk_pkg::*; #(
	parameter int SCAN_CYCLES = 6_250
) (
	input logic CLK_EXT,
	input logic rst_n,
	input mach_status_s mstat,
	input panel_state_s state,
	output logic [7:0] seg,
	output logic [7:0] dig
);

	localparam int SW = $clog2(SCAN_CYCLES + 1);

	logic [SW-1:0] scan_cnt;
	logic [2:0] digit;
	logic [7:0] dots;
	logic [6:0] glyph;
	// left glyph in 13:7, right glyph in 6:0
	logic [13:0] reg_glyphs;

	// segments g..a, active high
	function automatic logic [6:0] hex_seg(input logic [3:0] h);
		case (h)
			4'h0: return 7'h3f;
			4'h1: return 7'h06;
			4'h2: return 7'h5b;
			4'h3: return 7'h4f;
			4'h4: return 7'h66;
			4'h5: return 7'h6d;
			4'h6: return 7'h7d;
			4'h7: return 7'h07;
			4'h8: return 7'h7f;
			4'h9: return 7'h6f;
			4'ha: return 7'h77;
			4'hb: return 7'h7c;
			4'hc: return 7'h39;
			4'hd: return 7'h5e;
			4'he: return 7'h79;
			default: return 7'h71;
		endcase
	endfunction

	always_ff @(posedge CLK_EXT or negedge rst_n) begin
		if (!rst_n) begin
			scan_cnt <= '0;
			digit <= '0;
		end else if (scan_cnt == SW'(SCAN_CYCLES - 1)) begin
			scan_cnt <= '0;
			digit <= digit + 1'b1;
		end else begin
			scan_cnt <= scan_cnt + 1'b1;
		end
	end

	// r0..r7 show "r" and the number, others a two letter name
	always_comb begin
		if (state.rot_bus[10]) begin
			reg_glyphs = {7'h50, hex_seg({1'b0, state.rot_bus[9:7]})};
		end else begin
			case (state.rot_bus)
				ROT_BUS_IC: reg_glyphs = {7'h30, 7'h39};
				ROT_BUS_AC: reg_glyphs = {7'h77, 7'h39};
				ROT_BUS_AR: reg_glyphs = {7'h77, 7'h50};
				ROT_BUS_IR: reg_glyphs = {7'h30, 7'h50};
				ROT_BUS_SR: reg_glyphs = {7'h6d, 7'h50};
				ROT_BUS_RZ: reg_glyphs = {7'h50, 7'h5b};
				ROT_BUS_KB: reg_glyphs = {7'h75, 7'h7c};
				default: reg_glyphs = '0;
			endcase
		end
	end

	always_comb begin
		case (digit)
			3'd0: glyph = hex_seg(mstat.w[12:15]);
			3'd1: glyph = hex_seg(mstat.w[8:11]);
			3'd2: glyph = hex_seg(mstat.w[4:7]);
			3'd3: glyph = hex_seg(mstat.w[0:3]);
			3'd4: glyph = '0;
			3'd5: glyph = reg_glyphs[6:0];
			3'd6: glyph = reg_glyphs[13:7];
			default: glyph = {~mstat.mc_0, 5'b00000, mstat.p};
		endcase
	end

	assign dots = {mstat.run, mstat.wait_in, mstat.alarm, mstat.irq,
		state.fnkey[FN_MODE], mstat.stop_n, state.fnkey[FN_CLOCK], mstat.q};

	assign seg = {dots[digit], glyph};
	assign dig = 8'b0000_0001 << digit;

endmodule

/* hdl/panel_signals.sv */
//////////////////////////////////////////////////
// panel control lines
// start/stop pulses, stop_n flip-flop, p0 gated
// memory keys and the zegar clock tick
//////////////////////////////////////////////////
`timescale 1ns/10ps

module panel_signals import pk_pkg::*; #(
	parameter int TIMER_PERIOD = 50_000
) (
	input logic CLK_EXT,
	input logic rst_n,
	input fnkey_t fnkey,
	input logic hlt_n,
	input logic p0,
	output logic start,
	output logic stop,
	output logic stop_n,
	output logic fetch,
	output logic store,
	output logic cycle,
	output logic load,
	output logic bin,
	output logic zegar
);

	localparam int TW = $clog2(TIMER_PERIOD + 1);

	logic start_key_d;
	logic stopn_key_d;
	logic stopn_rise;
	logic clr_n;
	logic [TW-1:0] timer_cnt;

	assign stopn_rise = fnkey[FN_STOPN] & ~stopn_key_d;
	// hlt_n from the machine clears stop_n at once
	assign clr_n = rst_n & hlt_n;

	always_ff @(posedge CLK_EXT or negedge rst_n) begin
		if (!rst_n) begin
			start_key_d <= 1'b0;
			stopn_key_d <= 1'b0;
			start <= 1'b0;
			stop <= 1'b0;
			timer_cnt <= TW'(TIMER_PERIOD - 1);
		end else begin
			start_key_d <= fnkey[FN_START];
			stopn_key_d <= fnkey[FN_STOPN];
			start <= fnkey[FN_START] & ~start_key_d;
			stop <= ~fnkey[FN_START] & start_key_d;
			// free running, the clock key only gates the output
			if (timer_cnt == '0)
				timer_cnt <= TW'(TIMER_PERIOD - 1);
			else
				timer_cnt <= timer_cnt - 1'b1;
		end
	end

	always_ff @(posedge CLK_EXT or negedge clr_n) begin
		if (!clr_n)
			stop_n <= 1'b0;
		else if (stopn_rise)
			stop_n <= ~stop_n;
	end

	assign fetch = fnkey[FN_FETCH] & p0;
	assign store = fnkey[FN_STORE] & p0;
	assign cycle = fnkey[FN_CYCLE] & p0;
	assign load = fnkey[FN_LOAD] & p0;
	assign bin = fnkey[FN_BIN] & p0;

	assign zegar = fnkey[FN_CLOCK] & (timer_cnt == '0);

endmodule

/* hdl/status_reporter.sv */
//////////////////////////////////////////////////
// status reporter
// answers a status request with four bytes on
// the uart, one byte per transmitter round trip
//////////////////////////////////////////////////
`timescale 1ns/10ps

module status_reporter import pk_pkg::*; (
	input logic CLK_EXT,
	input logic rst_n,
	input logic status_req,
	input logic tx_busy,
	input panel_state_s state,
	input mach_status_s mstat,
	output byte_t tx_byte,
	output logic tx_send
);

	typedef enum logic [1:0] {S_IDLE, S_SEND, S_WAIT_BUSY, S_WAIT_DONE} rep_state_e;

	rep_state_e rstate;
	logic [1:0] byte_cnt;
	byte_t frame_byte;

	always_comb begin
		case (byte_cnt)
			2'd0: frame_byte = mstat.w[0:7];
			2'd1: frame_byte = mstat.w[8:15];
			2'd2: frame_byte = {state.fnkey[FN_MODE], mstat.stop_n, state.fnkey[FN_CLOCK],
				mstat.q, mstat.p, ~mstat.mc_0, mstat.irq, mstat.run};
			default: frame_byte = {state.rot_pos, 2'b00, mstat.wait_in, mstat.alarm};
		endcase
	end

	always_ff @(posedge CLK_EXT or negedge rst_n) begin
		if (!rst_n) begin
			rstate <= S_IDLE;
			byte_cnt <= '0;
			tx_send <= 1'b0;
		end else begin
			tx_send <= 1'b0;
			case (rstate)
				S_IDLE: begin
					byte_cnt <= '0;
					// requests while the line is busy are lost
					if (status_req && !tx_busy)
						rstate <= S_SEND;
				end
				S_SEND: begin
					tx_send <= 1'b1;
					rstate <= S_WAIT_BUSY;
				end
				S_WAIT_BUSY: if (tx_busy) rstate <= S_WAIT_DONE;
				default: begin
					if (!tx_busy) begin
						byte_cnt <= byte_cnt + 1'b1;
						rstate <= (byte_cnt == 2'd3) ? S_IDLE : S_SEND;
					end
				end
			endcase
		end
	end

	// byte is frozen at the moment it is handed over
	always_ff @(posedge CLK_EXT) begin
		if (rstate == S_SEND)
			tx_byte <= frame_byte;
	end

endmodule

/* hdl/panel_cmd_decoder.sv */
//////////////////////////////////////////////////
// panel command decoder
// turns host command bytes into function keys,
// data keys and rotary switch state, and ends
// momentary keys after a fixed pulse
//////////////////////////////////////////////////
`timescale 1ns/10ps

module panel_cmd_decoder import pk_pkg::*; #(
	parameter int KEY_PULSE_CYCLES = 50
) (
	input logic CLK_EXT,
	input logic rst_n,
	input byte_t rx_byte,
	input logic rx_valid,
	output panel_state_s state,
	output logic status_req
);

	localparam int PW = $clog2(KEY_PULSE_CYCLES + 1);

	cmd_class_e cmd;
	logic [3:0] key_idx;
	logic key_valid;
	logic pulse_load;
	logic [PW-1:0] pulse_cnt;

	assign cmd = cmd_class_e'(rx_byte[7:5]);
	assign key_idx = rx_byte[4:1];
	assign key_valid = (key_idx <= FN_CLEAR);
	// setting any momentary key restarts the shared pulse
	assign pulse_load = rx_valid && cmd == CMD_FNKEY && rx_byte[0]
		&& key_valid && FN_MOMENTARY[key_idx];

	always_ff @(posedge CLK_EXT or negedge rst_n) begin
		if (!rst_n) begin
			state.fnkey <= '0;
			state.keys <= '0;
			state.rot_pos <= ROT_POS_R1;
			state.rot_bus <= ROT_BUS_R1;
			status_req <= 1'b0;
			pulse_cnt <= '0;
		end else begin
			status_req <= 1'b0;
			if (pulse_load)
				pulse_cnt <= PW'(KEY_PULSE_CYCLES - 1);
			else if (pulse_cnt != '0)
				pulse_cnt <= pulse_cnt - 1'b1;
			// pulse over, a new key write below still wins
			if (pulse_cnt == '0)
				state.fnkey <= state.fnkey & ~FN_MOMENTARY;
			if (rx_valid) begin
				case (cmd)
					CMD_FNKEY: begin
						if (key_valid)
							state.fnkey[key_idx] <= rx_byte[0];
					end
					// word bit 15 is the lsb, so field 5:0 is kl[10:15]
					CMD_KEYS_LO, CMD_KEYS_LO_B: state.keys[10:15] <= rx_byte[5:0];
					CMD_KEYS_MID: state.keys[5:9] <= rx_byte[4:0];
					CMD_KEYS_HI: state.keys[0:4] <= rx_byte[4:0];
					CMD_STATUS: status_req <= 1'b1;
					CMD_ROTARY: begin
						state.rot_pos <= rx_byte[3:0];
						state.rot_bus <= ROT_BUS_TABLE[rx_byte[3:0]];
					end
					default: ;
				endcase
			end
		end
	end

endmodule

/* uart/uart_tx.sv */
//////////////////////////////////////////////////
// uart transmitter, 8N1
// busy from the cycle after send until the end
// of the stop bit
//////////////////////////////////////////////////
`timescale 1ns/10ps

module uart_tx import pk_pkg::*; #(
	parameter int CLKS_PER_BIT = 16
) (
	input logic CLK_EXT,
	input logic rst_n,
	input byte_t tx_byte,
	input logic tx_send,
	output logic txd,
	output logic tx_busy
);

	localparam int CW = $clog2(CLKS_PER_BIT + 1);

	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

	tx_state_e state;
	logic [CW-1:0] clk_cnt;
	logic [2:0] bit_cnt;
	byte_t data_q;

	assign tx_busy = (state != TX_IDLE);

	always_ff @(posedge CLK_EXT or negedge rst_n) begin
		if (!rst_n) begin
			state <= TX_IDLE;
			txd <= 1'b1;
			clk_cnt <= '0;
			bit_cnt <= '0;
		end else if (state == TX_IDLE) begin
			if (tx_send) begin
				state <= TX_START;
				txd <= 1'b0;
				clk_cnt <= CW'(CLKS_PER_BIT - 1);
			end
		end else if (clk_cnt != '0) begin
			clk_cnt <= clk_cnt - 1'b1;
		end else begin
			clk_cnt <= CW'(CLKS_PER_BIT - 1);
			case (state)
				TX_START: begin
					state <= TX_DATA;
					txd <= data_q[0];
					bit_cnt <= '0;
				end
				TX_DATA: begin
					if (bit_cnt == 3'd7) begin
						state <= TX_STOP;
						txd <= 1'b1;
					end else begin
						txd <= data_q[bit_cnt + 1'b1];
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK_EXT) begin
		if (state == TX_IDLE && tx_send)
			data_q <= tx_byte;
	end

endmodule

/* uart/uart_rx.sv */
//////////////////////////////////////////////////
// uart receiver, 8N1
// samples each bit in its middle and strobes
// rx_valid once per good frame
//////////////////////////////////////////////////
`timescale 1ns/10ps

module uart_rx import pk_pkg::*; #(
	parameter int CLKS_PER_BIT = 16
) (
	input logic CLK_EXT,
	input logic rst_n,
	input logic rxd,
	output byte_t rx_byte,
	output logic rx_valid
);

	localparam int CW = $clog2(CLKS_PER_BIT + 1);

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

	rx_state_e state;
	logic [1:0] rxd_sync;
	logic [CW-1:0] clk_cnt;
	logic [2:0] bit_cnt;
	logic rxd_s;
	logic sample;

	assign rxd_s = rxd_sync[1];
	assign sample = (state != RX_IDLE) && (clk_cnt == '0);

	always_ff @(posedge CLK_EXT or negedge rst_n) begin
		if (!rst_n) begin
			state <= RX_IDLE;
			rxd_sync <= 2'b11;
			clk_cnt <= '0;
			bit_cnt <= '0;
			rx_valid <= 1'b0;
		end else begin
			rxd_sync <= {rxd_sync[0], rxd};
			rx_valid <= 1'b0;
			if (state == RX_IDLE) begin
				// half a bit to reach the middle of the start bit
				if (!rxd_s) begin
					state <= RX_START;
					clk_cnt <= CW'(CLKS_PER_BIT / 2 - 1);
				end
			end else if (!sample) begin
				clk_cnt <= clk_cnt - 1'b1;
			end else begin
				clk_cnt <= CW'(CLKS_PER_BIT - 1);
				case (state)
					RX_START: begin
						// glitch, not a start bit
						state <= rxd_s ? RX_IDLE : RX_DATA;
						bit_cnt <= '0;
					end
					RX_DATA: begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7)
							state <= RX_STOP;
					end
					default: begin
						// bad stop bit drops the frame
						rx_valid <= rxd_s;
						state <= RX_IDLE;
					end
				endcase
			end
		end
	end

	// lsb first
	always_ff @(posedge CLK_EXT) begin
		if (sample && state == RX_DATA)
			rx_byte <= {rxd_s, rx_byte[7:1]};
	end

endmodule

/* common/pk_pkg.sv */
//////////////////////////////////////////////////
// pk shared definitions
// command classes, function key indices, rotary
// bus codes and the vector types of the panel
//////////////////////////////////////////////////
package pk_pkg;

	typedef logic [7:0] byte_t;
	// bit 0 is the most significant, as on the machine
	typedef logic [0:15] word_t;
	typedef logic [11:0] fnkey_t;
	typedef logic [3:0] rot_pos_t;
	// wre_, rsc, rsb, rsa, wic, wac, war, wir, wrs, wrz, wkb
	typedef logic [10:0] rot_bus_t;

	typedef enum logic [3:0] {
		FN_START, FN_MODE, FN_CLOCK, FN_STOPN, FN_STEP, FN_FETCH,
		FN_STORE, FN_CYCLE, FN_LOAD, FN_BIN, FN_OPRQ, FN_CLEAR
	} fn_idx_e;

	// stopn up to clear are momentary
	localparam fnkey_t FN_MOMENTARY = 12'b1111_1111_1000;

	// top three bits of a command byte
	typedef enum logic [2:0] {
		CMD_UNUSED   = 3'd0,
		CMD_FNKEY    = 3'd1,
		CMD_KEYS_LO  = 3'd2,
		CMD_KEYS_LO_B = 3'd3,
		CMD_KEYS_MID = 3'd4,
		CMD_KEYS_HI  = 3'd5,
		CMD_STATUS   = 3'd6,
		CMD_ROTARY   = 3'd7
	} cmd_class_e;

	localparam rot_pos_t ROT_POS_R1 = 4'd1;

	localparam rot_bus_t ROT_BUS_R0 = 11'b100_0000_0000;
	localparam rot_bus_t ROT_BUS_R1 = 11'b100_1000_0000;
	localparam rot_bus_t ROT_BUS_R2 = 11'b101_0000_0000;
	localparam rot_bus_t ROT_BUS_R3 = 11'b101_1000_0000;
	localparam rot_bus_t ROT_BUS_R4 = 11'b110_0000_0000;
	localparam rot_bus_t ROT_BUS_R5 = 11'b110_1000_0000;
	localparam rot_bus_t ROT_BUS_R6 = 11'b111_0000_0000;
	localparam rot_bus_t ROT_BUS_R7 = 11'b111_1000_0000;
	localparam rot_bus_t ROT_BUS_IC = 11'b000_0100_0000;
	localparam rot_bus_t ROT_BUS_AC = 11'b000_0010_0000;
	localparam rot_bus_t ROT_BUS_AR = 11'b000_0001_0000;
	localparam rot_bus_t ROT_BUS_IR = 11'b000_0000_1000;
	localparam rot_bus_t ROT_BUS_SR = 11'b000_0000_0100;
	localparam rot_bus_t ROT_BUS_RZ = 11'b000_0000_0010;
	localparam rot_bus_t ROT_BUS_KB = 11'b000_0000_0001;

	// indexed by rotary position, 14 and 15 both select kb
	localparam rot_bus_t ROT_BUS_TABLE [0:15] = '{
		ROT_BUS_R0, ROT_BUS_R1, ROT_BUS_R2, ROT_BUS_R3,
		ROT_BUS_R4, ROT_BUS_R5, ROT_BUS_R6, ROT_BUS_R7,
		ROT_BUS_IC, ROT_BUS_AC, ROT_BUS_AR, ROT_BUS_IR,
		ROT_BUS_SR, ROT_BUS_RZ, ROT_BUS_KB, ROT_BUS_KB
	};

	typedef struct packed {
		fnkey_t fnkey;
		word_t keys;
		rot_pos_t rot_pos;
		rot_bus_t rot_bus;
	} panel_state_s;

	// machine lamps, plus the panel's own stop_n flip-flop
	typedef struct packed {
		word_t w;
		logic p;
		logic mc_0;
		logic alarm;
		logic wait_in;
		logic irq;
		logic q;
		logic run;
		logic stop_n;
	} mach_status_s;

endpackage
